// File: rtl/fpu_micro_pkg.sv
package fpu_micro_pkg;

	// word widths
	localparam int sig_width = 32;
	localparam int exp_width = 10; // two guard bits above the 8-bit exponent
	localparam int sig_norm_bit = 29; // hidden one after normalization

	typedef logic [sig_width-1:0] sig_word_t;
	typedef logic [exp_width-1:0] exp_word_t; // two's complement, biased
	typedef logic [3:0] reg_sel_t;

	// read select codes, 10 to 14 are undefined
	localparam reg_sel_t sel_r0 = 4'd0;
	localparam reg_sel_t sel_r1 = 4'd1;
	localparam reg_sel_t sel_c0 = 4'd2;
	localparam reg_sel_t sel_c1 = 4'd3;
	localparam reg_sel_t sel_c2 = 4'd4;
	localparam reg_sel_t sel_c3 = 4'd5;
	localparam reg_sel_t sel_c4 = 4'd6;
	localparam reg_sel_t sel_c5 = 4'd7;
	localparam reg_sel_t sel_c6 = 4'd8;
	localparam reg_sel_t sel_c7 = 4'd9;
	localparam reg_sel_t sel_c_ones = 4'd15;

	// significand constant bank, codes 2..9 and 15
	localparam sig_word_t sig_const_zero = 32'd0;
	localparam sig_word_t sig_const_one = 32'd1;
	localparam sig_word_t sig_const_two = 32'd2;
	localparam sig_word_t sig_const_ulp = 32'd128; // rounding ulp
	localparam sig_word_t sig_const_bias = 32'd127;
	localparam sig_word_t sig_const_five = 32'd5; // div/sqrt normalization
	localparam sig_word_t sig_const_six = 32'd6;
	localparam sig_word_t sig_const_nan = 32'h2000_0000; // NaN significand
	localparam sig_word_t sig_const_ones = 32'hffff_ffff;

	// exponent constant bank, bias sits on the same code as in the significand lane
	localparam exp_word_t exp_const_zero = 10'd0;
	localparam exp_word_t exp_const_one = 10'd1;
	localparam exp_word_t exp_const_two = 10'd2;
	localparam exp_word_t exp_const_max = 10'd255; // inf/NaN exponent
	localparam exp_word_t exp_const_bias = 10'd127;
	localparam exp_word_t exp_const_five = 10'd5;
	localparam exp_word_t exp_const_six = 10'd6;
	localparam exp_word_t exp_const_mant = 10'd23; // stored mantissa bits
	localparam exp_word_t exp_const_ones = 10'h3ff;

	typedef enum logic [1:0] {
		pass_a = 2'd0,
		add = 2'd1,
		sub = 2'd2,
		shr = 2'd3 // zero filled
	} alu_op_t;

	typedef struct packed {
		reg_sel_t sig_sel_a;
		reg_sel_t sig_sel_b;
		alu_op_t sig_op;
		reg_sel_t exp_sel_a;
		reg_sel_t exp_sel_b;
		alu_op_t exp_op;
		logic sig_wr_r0;
		logic sig_wr_r1;
		logic exp_wr_r0;
		logic exp_wr_r1;
		logic load; // write operand instead of alu result
		logic norm_step; // sig r0 << 1, exp r0 - 1
	} micro_op_t;

	typedef struct packed {
		logic sig_zero;
		logic sig_norm;
		logic exp_ovf;
		logic exp_unf;
		logic is_nan;
	} fpu_flags_t;

endpackage

// File: rtl/sig_register_file.sv
`timescale 1ns/1ps

module sig_register_file (
	input logic clk_in,
	input logic reset_in,
	input logic wr_r0,
	input logic wr_r1,
	input logic shift_r0,
	input fpu_micro_pkg::sig_word_t wr_value,
	input fpu_micro_pkg::reg_sel_t sel_a,
	input fpu_micro_pkg::reg_sel_t sel_b,
	output fpu_micro_pkg::sig_word_t rd_a,
	output fpu_micro_pkg::sig_word_t rd_b
);

	fpu_micro_pkg::sig_word_t r0;
	fpu_micro_pkg::sig_word_t r1;
	fpu_micro_pkg::sig_word_t r0_written;
	fpu_micro_pkg::sig_word_t r0_next;

	// one read port, registers or constant bank
	function automatic fpu_micro_pkg::sig_word_t read_port(
		input fpu_micro_pkg::reg_sel_t sel,
		input fpu_micro_pkg::sig_word_t reg0,
		input fpu_micro_pkg::sig_word_t reg1
	);
		fpu_micro_pkg::sig_word_t value;
		case (sel)
			fpu_micro_pkg::sel_r0: value = reg0;
			fpu_micro_pkg::sel_r1: value = reg1;
			fpu_micro_pkg::sel_c0: value = fpu_micro_pkg::sig_const_zero;
			fpu_micro_pkg::sel_c1: value = fpu_micro_pkg::sig_const_one;
			fpu_micro_pkg::sel_c2: value = fpu_micro_pkg::sig_const_two;
			fpu_micro_pkg::sel_c3: value = fpu_micro_pkg::sig_const_ulp;
			fpu_micro_pkg::sel_c4: value = fpu_micro_pkg::sig_const_bias;
			fpu_micro_pkg::sel_c5: value = fpu_micro_pkg::sig_const_five;
			fpu_micro_pkg::sel_c6: value = fpu_micro_pkg::sig_const_six;
			fpu_micro_pkg::sel_c7: value = fpu_micro_pkg::sig_const_nan;
			fpu_micro_pkg::sel_c_ones: value = fpu_micro_pkg::sig_const_ones;
			default: value = '0; // undefined codes read zero
		endcase
		return value;
	endfunction

	assign rd_a = read_port(sel_a, r0, r1);
	assign rd_b = read_port(sel_b, r0, r1);

	// write lands first, the normalization shift then acts on it
	always_comb begin
		r0_written = wr_r0 ? wr_value : r0;
		r0_next = shift_r0 ? (r0_written << 1) : r0_written;
	end

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			r0 <= '0;
			r1 <= '0;
		end else begin
			r0 <= r0_next;
			if (wr_r1)
				r1 <= wr_value;
		end
	end

endmodule

// File: rtl/exp_register_file.sv
`timescale 1ns/1ps

module exp_register_file (
	input logic clk_in,
	input logic reset_in,
	input logic wr_r0,
	input logic wr_r1,
	input logic dec_r0,
	input fpu_micro_pkg::exp_word_t wr_value,
	input fpu_micro_pkg::reg_sel_t sel_a,
	input fpu_micro_pkg::reg_sel_t sel_b,
	output fpu_micro_pkg::exp_word_t rd_a,
	output fpu_micro_pkg::exp_word_t rd_b
);

	fpu_micro_pkg::exp_word_t r0;
	fpu_micro_pkg::exp_word_t r1;
	fpu_micro_pkg::exp_word_t r0_written;
	fpu_micro_pkg::exp_word_t r0_next;

	function automatic fpu_micro_pkg::exp_word_t read_port(
		input fpu_micro_pkg::reg_sel_t sel,
		input fpu_micro_pkg::exp_word_t reg0,
		input fpu_micro_pkg::exp_word_t reg1
	);
		fpu_micro_pkg::exp_word_t value;
		case (sel)
			fpu_micro_pkg::sel_r0: value = reg0;
			fpu_micro_pkg::sel_r1: value = reg1;
			fpu_micro_pkg::sel_c0: value = fpu_micro_pkg::exp_const_zero;
			fpu_micro_pkg::sel_c1: value = fpu_micro_pkg::exp_const_one;
			fpu_micro_pkg::sel_c2: value = fpu_micro_pkg::exp_const_two;
			fpu_micro_pkg::sel_c3: value = fpu_micro_pkg::exp_const_max;
			fpu_micro_pkg::sel_c4: value = fpu_micro_pkg::exp_const_bias;
			fpu_micro_pkg::sel_c5: value = fpu_micro_pkg::exp_const_five;
			fpu_micro_pkg::sel_c6: value = fpu_micro_pkg::exp_const_six;
			fpu_micro_pkg::sel_c7: value = fpu_micro_pkg::exp_const_mant;
			fpu_micro_pkg::sel_c_ones: value = fpu_micro_pkg::exp_const_ones;
			default: value = '0;
		endcase
		return value;
	endfunction

	assign rd_a = read_port(sel_a, r0, r1);
	assign rd_b = read_port(sel_b, r0, r1);

	// decrement tracks each significand shift, applied after any write
	always_comb begin
		r0_written = wr_r0 ? wr_value : r0;
		r0_next = dec_r0 ? (r0_written - fpu_micro_pkg::exp_word_t'(1)) : r0_written; // wraps
	end

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			r0 <= '0;
			r1 <= '0;
		end else begin
			r0 <= r0_next;
			if (wr_r1)
				r1 <= wr_value;
		end
	end

endmodule

// File: rtl/micro_alu.sv
`timescale 1ns/1ps

module micro_alu #(
	parameter type word_t = fpu_micro_pkg::sig_word_t
) (
	input logic clk_in,
	input logic reset_in,
	input fpu_micro_pkg::alu_op_t op,
	input word_t a,
	input word_t b,
	output word_t result
);

	word_t result_next;

	// all arithmetic wraps in the width of word_t
	always_comb begin
		result_next = a;
		case (op)
			fpu_micro_pkg::pass_a: begin
				result_next = a;
			end
			fpu_micro_pkg::add: begin
				result_next = word_t'(a + b);
			end
			fpu_micro_pkg::sub: begin
				result_next = word_t'(a - b);
			end
			fpu_micro_pkg::shr: begin
				result_next = a >> 1; // zero fill at the top
			end
			default: begin
				result_next = a;
			end
		endcase
	end

	always_ff @(posedge clk_in) begin
		if (reset_in)
			result <= '0;
		else
			result <= result_next;
	end

endmodule

// File: rtl/status_combiner.sv
`timescale 1ns/1ps

module status_combiner (
	input logic clk_in,
	input logic reset_in,
	input fpu_micro_pkg::sig_word_t sig_result,
	input fpu_micro_pkg::exp_word_t exp_result,
	output fpu_micro_pkg::fpu_flags_t flags
);

	fpu_micro_pkg::fpu_flags_t flags_next;
	logic exp_negative;
	logic sig_nonzero;

	assign exp_negative = exp_result[fpu_micro_pkg::exp_width-1]; // sign of the guard bits
	assign sig_nonzero = |sig_result;

	always_comb begin
		flags_next.sig_zero = !sig_nonzero;
		flags_next.sig_norm = sig_result[fpu_micro_pkg::sig_norm_bit];
		flags_next.exp_unf = exp_negative;
		// unsigned compare is safe once the sign is known clear
		flags_next.exp_ovf = !exp_negative && (exp_result >= fpu_micro_pkg::exp_const_max);
		// max exponent with zero significand is infinity, not NaN
		flags_next.is_nan = (exp_result == fpu_micro_pkg::exp_const_max) && sig_nonzero;
	end

	always_ff @(posedge clk_in) begin
		if (reset_in)
			flags <= '0;
		else
			flags <= flags_next;
	end

endmodule

// File: rtl/fpu_datapath.sv
`timescale 1ns/1ps

module fpu_datapath (
	input logic clk_in,
	input logic reset_in,
	input fpu_micro_pkg::micro_op_t micro_op,
	input fpu_micro_pkg::sig_word_t sig_operand,
	input fpu_micro_pkg::exp_word_t exp_operand,
	output fpu_micro_pkg::sig_word_t sig_result,
	output fpu_micro_pkg::exp_word_t exp_result,
	output fpu_micro_pkg::fpu_flags_t flags
);

	fpu_micro_pkg::sig_word_t sig_rd_a;
	fpu_micro_pkg::sig_word_t sig_rd_b;
	fpu_micro_pkg::sig_word_t sig_wr_value;
	fpu_micro_pkg::exp_word_t exp_rd_a;
	fpu_micro_pkg::exp_word_t exp_rd_b;
	fpu_micro_pkg::exp_word_t exp_wr_value;

	// write-back is either the operand or the previous op's result
	assign sig_wr_value = micro_op.load ? sig_operand : sig_result;
	assign exp_wr_value = micro_op.load ? exp_operand : exp_result;

	sig_register_file u_sig_register_file (
		.clk_in(clk_in),
		.reset_in(reset_in),
		.wr_r0(micro_op.sig_wr_r0),
		.wr_r1(micro_op.sig_wr_r1),
		.shift_r0(micro_op.norm_step),
		.wr_value(sig_wr_value),
		.sel_a(micro_op.sig_sel_a),
		.sel_b(micro_op.sig_sel_b),
		.rd_a(sig_rd_a),
		.rd_b(sig_rd_b)
	);

	exp_register_file u_exp_register_file (
		.clk_in(clk_in),
		.reset_in(reset_in),
		.wr_r0(micro_op.exp_wr_r0),
		.wr_r1(micro_op.exp_wr_r1),
		.dec_r0(micro_op.norm_step), // same step as the significand shift
		.wr_value(exp_wr_value),
		.sel_a(micro_op.exp_sel_a),
		.sel_b(micro_op.exp_sel_b),
		.rd_a(exp_rd_a),
		.rd_b(exp_rd_b)
	);

	micro_alu #(.word_t(fpu_micro_pkg::sig_word_t)) u_sig_alu (
		.clk_in(clk_in),
		.reset_in(reset_in),
		.op(micro_op.sig_op),
		.a(sig_rd_a),
		.b(sig_rd_b),
		.result(sig_result)
	);

	micro_alu #(.word_t(fpu_micro_pkg::exp_word_t)) u_exp_alu (
		.clk_in(clk_in),
		.reset_in(reset_in),
		.op(micro_op.exp_op),
		.a(exp_rd_a),
		.b(exp_rd_b),
		.result(exp_result)
	);

	status_combiner u_status_combiner (
		.clk_in(clk_in),
		.reset_in(reset_in),
		.sig_result(sig_result),
		.exp_result(exp_result),
		.flags(flags)
	);

endmodule

// File: bench/fpu_datapath_sva.sv
`timescale 1ns/1ps

module fpu_datapath_sva #(
	parameter int width = 32
) (
	input logic clk_in,
	input logic reset_in,
	input fpu_micro_pkg::reg_sel_t sel_a,
	input fpu_micro_pkg::reg_sel_t sel_b,
	input logic [width-1:0] rd_a,
	input logic [width-1:0] rd_b
);

	// codes 10 to 14 have nothing behind them
	sel_a_defined: assert property (@(posedge clk_in) disable iff (reset_in)
		(sel_a < 4'd10 || sel_a > 4'd14))
		else $error("read select A used undefined code %0d", sel_a);

	sel_b_defined: assert property (@(posedge clk_in) disable iff (reset_in)
		(sel_b < 4'd10 || sel_b > 4'd14))
		else $error("read select B used undefined code %0d", sel_b);

	// R0 leaves reset cleared
	r0_clear_a: assert property (@(posedge clk_in)
		reset_in |=> (sel_a != fpu_micro_pkg::sel_r0 || rd_a == '0))
		else $error("read port A returned nonzero R0 right after reset");

	r0_clear_b: assert property (@(posedge clk_in)
		reset_in |=> (sel_b != fpu_micro_pkg::sel_r0 || rd_b == '0))
		else $error("read port B returned nonzero R0 right after reset");

endmodule

bind sig_register_file fpu_datapath_sva #(.width(fpu_micro_pkg::sig_width)) u_sva (
	.clk_in(clk_in), .reset_in(reset_in), .sel_a(sel_a), .sel_b(sel_b),
	.rd_a(rd_a), .rd_b(rd_b)
);

bind exp_register_file fpu_datapath_sva #(.width(fpu_micro_pkg::exp_width)) u_sva (
	.clk_in(clk_in), .reset_in(reset_in), .sel_a(sel_a), .sel_b(sel_b),
	.rd_a(rd_a), .rd_b(rd_b)
);

// File: bench/fpu_datapath_tb.sv
`timescale 1ns/1ps

module fpu_datapath_tb;

	typedef struct packed {
		fpu_micro_pkg::micro_op_t op;
		fpu_micro_pkg::sig_word_t sig_in;
		fpu_micro_pkg::exp_word_t exp_in;
		fpu_micro_pkg::sig_word_t sig_expect;
		fpu_micro_pkg::exp_word_t exp_expect;
		fpu_micro_pkg::fpu_flags_t flags_expect;
		logic [2:0] check_mask; // bit 0 sig, bit 1 exp, bit 2 flags
	} row_t;

	logic clk_in;
	logic reset_in;
	fpu_micro_pkg::micro_op_t micro_op;
	fpu_micro_pkg::sig_word_t sig_operand;
	fpu_micro_pkg::exp_word_t exp_operand;
	fpu_micro_pkg::sig_word_t sig_result;
	fpu_micro_pkg::exp_word_t exp_result;
	fpu_micro_pkg::fpu_flags_t flags;

	row_t rows[$];
	int mismatch_count;
	int other_count;

	fpu_datapath u_fpu_datapath (
		.clk_in(clk_in),
		.reset_in(reset_in),
		.micro_op(micro_op),
		.sig_operand(sig_operand),
		.exp_operand(exp_operand),
		.sig_result(sig_result),
		.exp_result(exp_result),
		.flags(flags)
	);

	initial begin
		clk_in = 1'b0;
		forever #10 clk_in = ~clk_in;
	end

	// hard stop if the run never reaches its end
	initial begin
		repeat (500) @(posedge clk_in);
		$display("timeout, testbench did not finish within 500 cycles");
		$display("Verification failed");
		$finish;
	end

	function automatic fpu_micro_pkg::micro_op_t make_op(
		input fpu_micro_pkg::reg_sel_t sig_a,
		input fpu_micro_pkg::reg_sel_t sig_b,
		input fpu_micro_pkg::alu_op_t sig_op,
		input fpu_micro_pkg::reg_sel_t exp_a,
		input fpu_micro_pkg::reg_sel_t exp_b,
		input fpu_micro_pkg::alu_op_t exp_op,
		input logic [3:0] wr, // sig r0, sig r1, exp r0, exp r1
		input logic load,
		input logic norm
	);
		fpu_micro_pkg::micro_op_t op;
		op.sig_sel_a = sig_a;
		op.sig_sel_b = sig_b;
		op.sig_op = sig_op;
		op.exp_sel_a = exp_a;
		op.exp_sel_b = exp_b;
		op.exp_op = exp_op;
		{op.sig_wr_r0, op.sig_wr_r1, op.exp_wr_r0, op.exp_wr_r1} = wr;
		op.load = load;
		op.norm_step = norm;
		return op;
	endfunction

	task automatic add_row(
		input fpu_micro_pkg::micro_op_t op,
		input fpu_micro_pkg::sig_word_t sig_in,
		input fpu_micro_pkg::exp_word_t exp_in,
		input fpu_micro_pkg::sig_word_t sig_expect,
		input fpu_micro_pkg::exp_word_t exp_expect,
		input logic [4:0] flags_expect,
		input logic [2:0] mask
	);
		row_t r;
		r.op = op;
		r.sig_in = sig_in;
		r.exp_in = exp_in;
		r.sig_expect = sig_expect;
		r.exp_expect = exp_expect;
		r.flags_expect = flags_expect;
		r.check_mask = mask;
		rows.push_back(r);
	endtask

	// flags column reads zero, norm, ovf, unf, nan
	task automatic build_table();
		// constants straight through pass_a
		add_row(make_op(4'd5, 4'd0, fpu_micro_pkg::pass_a, 4'd6, 4'd0, fpu_micro_pkg::pass_a,
			4'b0000, 1'b0, 1'b0), 32'h0, 10'h0, 32'h0000_0080, 10'h07f, 5'b00000, 3'b111);
		add_row(make_op(4'd9, 4'd0, fpu_micro_pkg::pass_a, 4'd5, 4'd0, fpu_micro_pkg::pass_a,
			4'b0000, 1'b0, 1'b0), 32'h0, 10'h0, 32'h2000_0000, 10'h0ff, 5'b01101, 3'b111);
		add_row(make_op(4'd2, 4'd0, fpu_micro_pkg::pass_a, 4'd5, 4'd0, fpu_micro_pkg::pass_a,
			4'b0000, 1'b0, 1'b0), 32'h0, 10'h0, 32'h0000_0000, 10'h0ff, 5'b10100, 3'b111);
		// load R0 then R1 in both lanes
		add_row(make_op(4'd15, 4'd0, fpu_micro_pkg::pass_a, 4'd15, 4'd0, fpu_micro_pkg::pass_a,
			4'b1010, 1'b1, 1'b0), 32'h1234_5678, 10'h064, 32'hffff_ffff, 10'h3ff, 5'b01010, 3'b111);
		add_row(make_op(4'd0, 4'd0, fpu_micro_pkg::pass_a, 4'd0, 4'd0, fpu_micro_pkg::pass_a,
			4'b0101, 1'b1, 1'b0), 32'hf000_0000, 10'h3a0, 32'h1234_5678, 10'h064, 5'b00000, 3'b111);
		add_row(make_op(4'd0, 4'd1, fpu_micro_pkg::add, 4'd0, 4'd1, fpu_micro_pkg::add,
			4'b0000, 1'b0, 1'b0), 32'h0, 10'h0, 32'h0234_5678, 10'h004, 5'b00000, 3'b111);
		// sub while the sum goes back into R1
		add_row(make_op(4'd0, 4'd1, fpu_micro_pkg::sub, 4'd0, 4'd1, fpu_micro_pkg::sub,
			4'b0101, 1'b0, 1'b0), 32'h0, 10'h0, 32'h2234_5678, 10'h0c4, 5'b01000, 3'b111);
		add_row(make_op(4'd1, 4'd0, fpu_micro_pkg::pass_a, 4'd1, 4'd0, fpu_micro_pkg::pass_a,
			4'b0000, 1'b0, 1'b0), 32'h0, 10'h0, 32'h0234_5678, 10'h004, 5'b00000, 3'b111);
		add_row(make_op(4'd1, 4'd1, fpu_micro_pkg::sub, 4'd1, 4'd1, fpu_micro_pkg::sub,
			4'b0000, 1'b0, 1'b0), 32'h0, 10'h0, 32'h0000_0000, 10'h000, 5'b10000, 3'b111);
		add_row(make_op(4'd3, 4'd0, fpu_micro_pkg::pass_a, 4'd2, 4'd3, fpu_micro_pkg::sub,
			4'b0000, 1'b0, 1'b0), 32'h0, 10'h0, 32'h0000_0001, 10'h3ff, 5'b00010, 3'b111);
		// normalization steps
		add_row(make_op(4'd0, 4'd0, fpu_micro_pkg::pass_a, 4'd0, 4'd0, fpu_micro_pkg::pass_a,
			4'b0000, 1'b0, 1'b1), 32'h0, 10'h0, 32'h1234_5678, 10'h064, 5'b00000, 3'b111);
		add_row(make_op(4'd0, 4'd0, fpu_micro_pkg::pass_a, 4'd0, 4'd0, fpu_micro_pkg::pass_a,
			4'b0000, 1'b0, 1'b0), 32'h0, 10'h0, 32'h2468_acf0, 10'h063, 5'b01000, 3'b111);
		add_row(make_op(4'd0, 4'd0, fpu_micro_pkg::pass_a, 4'd0, 4'd0, fpu_micro_pkg::pass_a,
			4'b1010, 1'b1, 1'b1), 32'h0c00_0003, 10'h081, 32'h2468_acf0, 10'h063, 5'b01000, 3'b111);
		add_row(make_op(4'd0, 4'd0, fpu_micro_pkg::pass_a, 4'd0, 4'd0, fpu_micro_pkg::pass_a,
			4'b0000, 1'b0, 1'b1), 32'h0, 10'h0, 32'h1800_0006, 10'h080, 5'b00000, 3'b111);
		add_row(make_op(4'd0, 4'd0, fpu_micro_pkg::pass_a, 4'd0, 4'd0, fpu_micro_pkg::pass_a,
			4'b0000, 1'b0, 1'b0), 32'h0, 10'h0, 32'h3000_000c, 10'h07f, 5'b01000, 3'b111);
		// shift right, lanes on different sources
		add_row(make_op(4'd15, 4'd0, fpu_micro_pkg::shr, 4'd0, 4'd0, fpu_micro_pkg::shr,
			4'b0000, 1'b0, 1'b0), 32'h0, 10'h0, 32'h7fff_ffff, 10'h03f, 5'b01000, 3'b111);
		add_row(make_op(4'd0, 4'd0, fpu_micro_pkg::shr, 4'd15, 4'd0, fpu_micro_pkg::shr,
			4'b0000, 1'b0, 1'b0), 32'h0, 10'h0, 32'h1800_0006, 10'h1ff, 5'b00100, 3'b111);
		// exponent either side of 255
		add_row(make_op(4'd5, 4'd3, fpu_micro_pkg::add, 4'd6, 4'd6, fpu_micro_pkg::add,
			4'b0000, 1'b0, 1'b0), 32'h0, 10'h0, 32'h0000_0081, 10'h0fe, 5'b00000, 3'b111);
		add_row(make_op(4'd9, 4'd0, fpu_micro_pkg::pass_a, 4'd5, 4'd3, fpu_micro_pkg::add,
			4'b0000, 1'b0, 1'b0), 32'h0, 10'h0, 32'h2000_0000, 10'h100, 5'b01100, 3'b111);
	endtask

	task automatic check_results(input int idx);
		row_t r;
		r = rows[idx];
		if (r.check_mask[0]) begin
			assert (sig_result == r.sig_expect) else begin
				$display("Mismatch sig_result row %0d: got %h, expected %h",
					idx, sig_result, r.sig_expect);
				mismatch_count++;
			end
		end
		if (r.check_mask[1]) begin
			assert (exp_result == r.exp_expect) else begin
				$display("Mismatch exp_result row %0d: got %h, expected %h",
					idx, exp_result, r.exp_expect);
				mismatch_count++;
			end
		end
	endtask

	task automatic check_flags(input int idx);
		row_t r;
		r = rows[idx];
		if (r.check_mask[2]) begin
			assert (flags == r.flags_expect) else begin
				$display("Mismatch flags row %0d: got %h, expected %h",
					idx, flags, r.flags_expect);
				mismatch_count++;
			end
		end
	endtask

	initial begin
		int n;
		reset_in = 1'b1;
		micro_op = '0;
		sig_operand = '0;
		exp_operand = '0;
		mismatch_count = 0;
		other_count = 0;
		build_table();
		n = rows.size();

		repeat (2) @(posedge clk_in);
		reset_in <= 1'b0;

		// outputs clear straight out of reset
		@(negedge clk_in);
		assert (sig_result == '0 && exp_result == '0 && flags == '0) else begin
			$display("results and flags did not read zero after reset");
			other_count++;
		end

		// results land one edge after sampling, flags one edge later
		for (int cyc = 0; cyc < n + 2; cyc++) begin
			@(posedge clk_in);
			if (cyc < n) begin
				micro_op <= rows[cyc].op;
				sig_operand <= rows[cyc].sig_in;
				exp_operand <= rows[cyc].exp_in;
			end else begin
				micro_op <= '0; // idle
				sig_operand <= '0;
				exp_operand <= '0;
			end
			@(negedge clk_in);
			if (cyc >= 1 && cyc - 1 < n)
				check_results(cyc - 1);
			if (cyc >= 2)
				check_flags(cyc - 2);
		end

		$display("errors: %0d (mismatches %0d, other failures %0d)",
			mismatch_count + other_count, mismatch_count, other_count);
		if (mismatch_count + other_count == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

// File: files.f
rtl/fpu_micro_pkg.sv
rtl/sig_register_file.sv
rtl/exp_register_file.sv
rtl/micro_alu.sv
rtl/status_combiner.sv
rtl/fpu_datapath.sv
bench/fpu_datapath_sva.sv
bench/fpu_datapath_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the fpu datapath testbench with Verilator

cd "$(dirname "$0")" || exit 1

top=fpu_datapath_tb
build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -f files.f --top-module "$top" -Mdir "$build_dir"
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

"./$build_dir/V$top" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Verification failed" "$log_file"; then
	echo "testbench reported failure, see $log_file"
	exit 1
fi

exit 0
